// ==== hw/dc_pkg.sv ====
`default_nettype none

package dc_pkg;

    // line geometry
    localparam int DC_WORD_W  = 16;  // bits per word, equal to the row count
    localparam int DC_ROWS    = 16;  // words per line
    localparam int DC_IDX_W   = 4;   // row or column index

    // address map
    localparam int AP_ADDR_W  = 16;  // tag in the upper bits, row in the lower 4
    localparam int DC_TAG_W   = 12;
    localparam int DDR_ADDR_W = 28;  // word address on the ddr side

    // processor commands
    typedef enum logic [2:0] {
        CMD_NOP       = 3'd0,
        CMD_ROW_READ  = 3'd1,
        CMD_ROW_WRITE = 3'd2,
        CMD_COL_READ  = 3'd3,
        CMD_COL_WRITE = 3'd4,
        CMD_FLUSH     = 3'd5
    } dc_cmd_e;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_WB   = 3'd1,  // old line going out
        ST_FILL = 3'd2,  // new line coming in
        ST_EXEC = 3'd3,
        ST_DONE = 3'd4
    } dc_state_e;

endpackage

`default_nettype wire

// ==== hw/bit_matrix.sv ====
`timescale 1ns/10ps
`default_nettype none

module bit_matrix (
    input  wire                          clk,
    input  wire                          rst,

    // processor row and column ports
    input  wire                          row_we,
    input  wire                          col_we,
    input  wire [dc_pkg::DC_IDX_W-1:0]   row_idx,
    input  wire [dc_pkg::DC_IDX_W-1:0]   col_idx,
    input  wire [dc_pkg::DC_WORD_W-1:0]  row_wdata,
    input  wire [dc_pkg::DC_WORD_W-1:0]  col_wdata,
    output logic [dc_pkg::DC_WORD_W-1:0] row_rdata,
    output logic [dc_pkg::DC_WORD_W-1:0] col_rdata,

    // fill write port
    input  wire                          fill_we,
    input  wire [dc_pkg::DC_IDX_W-1:0]   fill_idx,
    input  wire [dc_pkg::DC_WORD_W-1:0]  fill_data,

    // write-back read port
    input  wire [dc_pkg::DC_IDX_W-1:0]   wb_idx,
    output logic [dc_pkg::DC_WORD_W-1:0] wb_rdata
);
    import dc_pkg::*;

    logic [DC_WORD_W-1:0] mem [DC_ROWS];

    // fill and processor writes never overlap, fill wins anyway
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < DC_ROWS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int i = 0; i < DC_ROWS; i++) begin
                if (fill_we && fill_idx == DC_IDX_W'(i)) begin
                    mem[i] <= fill_data;
                end else if (row_we && row_idx == DC_IDX_W'(i)) begin
                    mem[i] <= row_wdata;
                end else if (col_we) begin
                    mem[i][col_idx] <= col_wdata[i];  // bit i of the column goes to word i
                end
            end
        end
    end

    assign row_rdata = mem[row_idx];
    assign wb_rdata  = mem[wb_idx];

    // column view: one bit from every word
    always_comb begin
        for (int j = 0; j < DC_ROWS; j++) begin
            col_rdata[j] = mem[j][col_idx];
        end
    end

endmodule

`default_nettype wire

// ==== hw/line_fill.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_fill (
    input  wire                           clk,
    input  wire                           rst,

    input  wire                           start,
    input  wire [dc_pkg::DDR_ADDR_W-1:0]  base,

    // ddr read side
    input  wire                           fifo_empty,
    input  wire [dc_pkg::DC_WORD_W-1:0]   fifo_data,
    output logic                          ddr_rd_req,
    output logic                          fifo_rd_en,
    output logic [dc_pkg::DDR_ADDR_W-1:0] ddr_rd_addr,

    // matrix write port
    output logic                          fill_we,
    output logic [dc_pkg::DC_IDX_W-1:0]   fill_idx,
    output logic [dc_pkg::DC_WORD_W-1:0]  fill_data,

    output logic                          done
);
    import dc_pkg::*;

    logic                busy;
    logic [DC_IDX_W-1:0] cnt;   // next row to fill
    logic                pop;
    logic                last;

    assign pop  = busy && !fifo_empty;
    assign last = cnt == DC_IDX_W'(DC_ROWS - 1);

    assign ddr_rd_req = busy;
    assign fifo_rd_en = pop;
    assign fill_we    = pop;  // each popped word lands in row cnt
    assign fill_idx   = cnt;
    assign fill_data  = fifo_data;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= pop && last;  // one cycle after the 16th pop
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (pop) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ddr_rd_addr <= base;
        end
    end

endmodule

`default_nettype wire

// ==== hw/line_writeback.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_writeback (
    input  wire                           clk,
    input  wire                           rst,

    input  wire                           start,
    input  wire [dc_pkg::DDR_ADDR_W-1:0]  base,

    // matrix read port
    input  wire [dc_pkg::DC_WORD_W-1:0]   wb_rdata,
    output logic [dc_pkg::DC_IDX_W-1:0]   wb_idx,

    // ddr write side, no back-pressure
    output logic                          ddr_wr_req,
    output logic                          ddr_wr_valid,
    output logic [dc_pkg::DDR_ADDR_W-1:0] ddr_wr_addr,
    output logic [dc_pkg::DC_WORD_W-1:0]  ddr_wr_data,

    output logic                          done
);
    import dc_pkg::*;

    logic                  busy;
    logic [DC_IDX_W-1:0]   cnt;
    logic [DDR_ADDR_W-1:0] base_q;

    assign wb_idx       = cnt;
    assign ddr_wr_req   = busy;
    assign ddr_wr_valid = busy;  // one word per cycle
    assign ddr_wr_addr  = base_q + DDR_ADDR_W'(cnt);
    assign ddr_wr_data  = wb_rdata;

    // comes with the last word
    assign done = busy && cnt == DC_IDX_W'(DC_ROWS - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            base_q <= base;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cache_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_fsm (
    input  wire                           clk,
    input  wire                           rst,

    // processor side held until rdy
    input  wire dc_pkg::dc_cmd_e          cmd,
    input  wire [dc_pkg::AP_ADDR_W-1:0]   addr,
    input  wire [dc_pkg::DC_IDX_W-1:0]    col,
    input  wire [dc_pkg::DC_WORD_W-1:0]   row_in,
    input  wire [dc_pkg::DC_WORD_W-1:0]   col_in,
    output logic                          rdy,

    // fill and write-back units
    input  wire                           fill_done,
    input  wire                           wb_done,
    output logic                          fill_start,
    output logic                          wb_start,
    output logic [dc_pkg::DDR_ADDR_W-1:0] fill_base,
    output logic [dc_pkg::DDR_ADDR_W-1:0] wb_base,

    // matrix processor ports
    output logic                          row_we,
    output logic                          col_we,
    output logic [dc_pkg::DC_IDX_W-1:0]   row_idx,
    output logic [dc_pkg::DC_IDX_W-1:0]   col_idx,
    output logic [dc_pkg::DC_WORD_W-1:0]  row_wdata,
    output logic [dc_pkg::DC_WORD_W-1:0]  col_wdata
);
    import dc_pkg::*;

    dc_state_e           state;
    dc_state_e           state_nx;
    logic [DC_TAG_W-1:0] tag_q;
    logic [DC_TAG_W-1:0] new_tag;
    logic                valid;
    logic                dirty;
    logic                hit;
    logic                is_flush;
    logic                is_write;

    assign new_tag  = addr[AP_ADDR_W-1:DC_IDX_W];
    assign hit      = valid && tag_q == new_tag;
    assign is_flush = cmd == CMD_FLUSH;
    assign is_write = cmd == CMD_ROW_WRITE || cmd == CMD_COL_WRITE;

    // line base is the tag shifted past the row bits
    assign wb_base   = DDR_ADDR_W'({tag_q, {DC_IDX_W{1'b0}}});
    assign fill_base = DDR_ADDR_W'({new_tag, {DC_IDX_W{1'b0}}});

    assign row_idx   = addr[DC_IDX_W-1:0];
    assign col_idx   = col;
    assign row_wdata = row_in;
    assign col_wdata = col_in;

    assign rdy    = state == ST_EXEC;
    assign row_we = rdy && cmd == CMD_ROW_WRITE;  // lands at the edge ending exec
    assign col_we = rdy && cmd == CMD_COL_WRITE;

    always_comb begin
        state_nx   = state;
        wb_start   = 1'b0;
        fill_start = 1'b0;
        case (state)
            ST_IDLE: begin
                if (cmd != CMD_NOP) begin
                    if ((is_flush || !hit) && valid && dirty) begin
                        wb_start = 1'b1;  // old line out first
                        state_nx = ST_WB;
                    end else if (is_flush || hit) begin
                        state_nx = ST_EXEC;
                    end else begin
                        fill_start = 1'b1;
                        state_nx   = ST_FILL;
                    end
                end
            end
            ST_WB: begin
                if (wb_done) begin
                    if (is_flush) begin
                        state_nx = ST_EXEC;
                    end else begin
                        fill_start = 1'b1;
                        state_nx   = ST_FILL;
                    end
                end
            end
            ST_FILL: begin
                if (fill_done) begin
                    state_nx = ST_EXEC;
                end
            end
            ST_EXEC: state_nx = ST_DONE;
            ST_DONE: state_nx = ST_IDLE;  // cmd is back to nop here
            default: state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
            tag_q <= '0;
            valid <= 1'b0;
            dirty <= 1'b0;
        end else begin
            state <= state_nx;
            if (state == ST_WB && wb_done) begin
                dirty <= 1'b0;
            end
            if (state == ST_FILL && fill_done) begin
                tag_q <= new_tag;
                valid <= 1'b1;
                dirty <= 1'b0;
            end
            if (rdy && is_write) begin
                dirty <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/data_cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_cache_top (
    input  wire                           clk,
    input  wire                           rst,

    // processor side
    input  wire dc_pkg::dc_cmd_e          cmd,
    input  wire [dc_pkg::AP_ADDR_W-1:0]   addr,
    input  wire [dc_pkg::DC_IDX_W-1:0]    col,
    input  wire [dc_pkg::DC_WORD_W-1:0]   row_in,
    input  wire [dc_pkg::DC_WORD_W-1:0]   col_in,
    output wire                           rdy,
    output wire [dc_pkg::DC_WORD_W-1:0]   row_out,
    output wire [dc_pkg::DC_WORD_W-1:0]   col_out,

    // ddr side
    input  wire                           fifo_empty,
    input  wire [dc_pkg::DC_WORD_W-1:0]   fifo_data,
    output wire                           ddr_rd_req,
    output wire [dc_pkg::DDR_ADDR_W-1:0]  ddr_rd_addr,
    output wire                           fifo_rd_en,
    output wire                           ddr_wr_req,
    output wire                           ddr_wr_valid,
    output wire [dc_pkg::DDR_ADDR_W-1:0]  ddr_wr_addr,
    output wire [dc_pkg::DC_WORD_W-1:0]   ddr_wr_data
);
    import dc_pkg::*;

    wire                  fill_start;
    wire                  wb_start;
    wire                  fill_done;
    wire                  wb_done;
    wire [DDR_ADDR_W-1:0] fill_base;
    wire [DDR_ADDR_W-1:0] wb_base;

    wire                  row_we;
    wire                  col_we;
    wire [DC_IDX_W-1:0]   row_idx;
    wire [DC_IDX_W-1:0]   col_idx;
    wire [DC_WORD_W-1:0]  row_wdata;
    wire [DC_WORD_W-1:0]  col_wdata;

    wire                  fill_we;
    wire [DC_IDX_W-1:0]   fill_idx;
    wire [DC_WORD_W-1:0]  fill_data;
    wire [DC_IDX_W-1:0]   wb_idx;
    wire [DC_WORD_W-1:0]  wb_rdata;

    cache_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .addr       (addr),
        .col        (col),
        .row_in     (row_in),
        .col_in     (col_in),
        .rdy        (rdy),
        .fill_done  (fill_done),
        .wb_done    (wb_done),
        .fill_start (fill_start),
        .wb_start   (wb_start),
        .fill_base  (fill_base),
        .wb_base    (wb_base),
        .row_we     (row_we),
        .col_we     (col_we),
        .row_idx    (row_idx),
        .col_idx    (col_idx),
        .row_wdata  (row_wdata),
        .col_wdata  (col_wdata)
    );

    line_fill u_fill (
        .clk         (clk),
        .rst         (rst),
        .start       (fill_start),
        .base        (fill_base),
        .fifo_empty  (fifo_empty),
        .fifo_data   (fifo_data),
        .ddr_rd_req  (ddr_rd_req),
        .fifo_rd_en  (fifo_rd_en),
        .ddr_rd_addr (ddr_rd_addr),
        .fill_we     (fill_we),
        .fill_idx    (fill_idx),
        .fill_data   (fill_data),
        .done        (fill_done)
    );

    line_writeback u_wb (
        .clk          (clk),
        .rst          (rst),
        .start        (wb_start),
        .base         (wb_base),
        .wb_rdata     (wb_rdata),
        .wb_idx       (wb_idx),
        .ddr_wr_req   (ddr_wr_req),
        .ddr_wr_valid (ddr_wr_valid),
        .ddr_wr_addr  (ddr_wr_addr),
        .ddr_wr_data  (ddr_wr_data),
        .done         (wb_done)
    );

    // row_out and col_out are the matrix read ports as they are
    bit_matrix u_matrix (
        .clk       (clk),
        .rst       (rst),
        .row_we    (row_we),
        .col_we    (col_we),
        .row_idx   (row_idx),
        .col_idx   (col_idx),
        .row_wdata (row_wdata),
        .col_wdata (col_wdata),
        .row_rdata (row_out),
        .col_rdata (col_out),
        .fill_we   (fill_we),
        .fill_idx  (fill_idx),
        .fill_data (fill_data),
        .wb_idx    (wb_idx),
        .wb_rdata  (wb_rdata)
    );

endmodule

`default_nettype wire

// ==== sim/tb_ddr_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ddr_fifo (
    input  wire                           clk,
    input  wire                           rst,

    // line read side
    input  wire                           ddr_rd_req,
    input  wire [dc_pkg::DDR_ADDR_W-1:0]  ddr_rd_addr,
    input  wire                           fifo_rd_en,
    output logic                          fifo_empty,
    output logic [dc_pkg::DC_WORD_W-1:0]  fifo_data,

    // write capture
    input  wire                           ddr_wr_valid,
    input  wire [dc_pkg::DDR_ADDR_W-1:0]  ddr_wr_addr,
    input  wire [dc_pkg::DC_WORD_W-1:0]   ddr_wr_data
);
    import dc_pkg::*;

    logic [DC_WORD_W-1:0] mem [logic [DDR_ADDR_W-1:0]];  // sparse store loaded by the testbench
    logic [DC_WORD_W-1:0] rd_q [$];
    logic                 req_q;
    logic                 gap;

    function automatic logic [DC_WORD_W-1:0] read_word(input logic [DDR_ADDR_W-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return '0;
    endfunction

    // outputs change only after the edge, so the DUT pops the word it saw
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_q.delete();
            req_q      <= 1'b0;
            fifo_empty <= 1'b1;
            fifo_data  <= '0;
        end else begin
            if (fifo_rd_en && rd_q.size() > 0) begin
                rd_q.delete(0);
            end
            if (ddr_rd_req && !req_q) begin  // new line request
                for (int i = 0; i < DC_ROWS; i++) begin
                    rd_q.push_back(read_word(ddr_rd_addr + DDR_ADDR_W'(i)));
                end
            end
            req_q <= ddr_rd_req;
            gap = ($urandom % 4) == 0;  // random bubbles in the fifo
            fifo_empty <= gap || rd_q.size() == 0;
            fifo_data  <= (rd_q.size() > 0) ? rd_q[0] : '0;
            if (ddr_wr_valid) begin
                mem[ddr_wr_addr] = ddr_wr_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_data_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_data_cache;
    import dc_pkg::*;

    localparam int N_CMDS  = 300;
    localparam int TIMEOUT = 500;  // cycles per command

    logic                  clk;
    logic                  rst;
    dc_cmd_e               cmd;
    logic [AP_ADDR_W-1:0]  addr;
    logic [DC_IDX_W-1:0]   col;
    logic [DC_WORD_W-1:0]  row_in;
    logic [DC_WORD_W-1:0]  col_in;
    wire                   rdy;
    wire [DC_WORD_W-1:0]   row_out;
    wire [DC_WORD_W-1:0]   col_out;
    wire                   fifo_empty;
    wire [DC_WORD_W-1:0]   fifo_data;
    wire                   ddr_rd_req;
    wire [DDR_ADDR_W-1:0]  ddr_rd_addr;
    wire                   fifo_rd_en;
    wire                   ddr_wr_req;
    wire                   ddr_wr_valid;
    wire [DDR_ADDR_W-1:0]  ddr_wr_addr;
    wire [DC_WORD_W-1:0]   ddr_wr_data;

    logic [DC_TAG_W-1:0]   tag_set [4];
    logic [DC_WORD_W-1:0]  golden [4][DC_ROWS];  // reference copy of every line
    logic                  held_valid;
    int                    held_k;
    logic                  held_dirty;
    logic [DDR_ADDR_W-1:0] wr_addr_q [$];
    logic [DC_WORD_W-1:0]  wr_data_q [$];
    logic [DDR_ADDR_W-1:0] fill_addr_q [$];
    logic                  rd_req_q;
    logic [DC_WORD_W-1:0]  got_row;
    logic [DC_WORD_W-1:0]  got_col;
    int                    value_errs;
    int                    event_errs;
    int                    n_done;

    data_cache_top u_dut (
        .clk(clk), .rst(rst), .cmd(cmd), .addr(addr), .col(col),
        .row_in(row_in), .col_in(col_in), .rdy(rdy), .row_out(row_out), .col_out(col_out),
        .fifo_empty(fifo_empty), .fifo_data(fifo_data), .ddr_rd_req(ddr_rd_req),
        .ddr_rd_addr(ddr_rd_addr), .fifo_rd_en(fifo_rd_en), .ddr_wr_req(ddr_wr_req),
        .ddr_wr_valid(ddr_wr_valid), .ddr_wr_addr(ddr_wr_addr), .ddr_wr_data(ddr_wr_data)
    );

    tb_ddr_fifo u_ddr (
        .clk(clk), .rst(rst), .ddr_rd_req(ddr_rd_req), .ddr_rd_addr(ddr_rd_addr),
        .fifo_rd_en(fifo_rd_en), .fifo_empty(fifo_empty), .fifo_data(fifo_data),
        .ddr_wr_valid(ddr_wr_valid), .ddr_wr_addr(ddr_wr_addr), .ddr_wr_data(ddr_wr_data)
    );

    always #50 clk = ~clk;

    // bus monitor with one entry per write pulse and per new read request
    always @(posedge clk) begin
        if (ddr_wr_valid) begin
            wr_addr_q.push_back(ddr_wr_addr);
            wr_data_q.push_back(ddr_wr_data);
            if (!ddr_wr_req) begin
                $display("write pulse to ddr while ddr_wr_req is low");
                event_errs++;
            end
        end
        if (ddr_rd_req && !rd_req_q) begin
            fill_addr_q.push_back(ddr_rd_addr);
        end
        rd_req_q <= ddr_rd_req;
    end

    function automatic logic [DDR_ADDR_W-1:0] line_base(input int k);
        return DDR_ADDR_W'(tag_set[k]) << DC_IDX_W;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        value_errs++;
    endtask

    // drives one command and holds it until rdy
    task automatic run_cmd(input dc_cmd_e c, input int k, input logic [DC_IDX_W-1:0] r,
                           input logic [DC_IDX_W-1:0] cc, input logic [DC_WORD_W-1:0] rin,
                           input logic [DC_WORD_W-1:0] cin);
        int   cycles;
        logic got;
        @(posedge clk);
        #5;
        wr_addr_q.delete();
        wr_data_q.delete();
        fill_addr_q.delete();
        cmd    = c;
        addr   = {tag_set[k], r};
        col    = cc;
        row_in = rin;
        col_in = cin;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (rdy) begin
                got     = 1'b1;
                got_row = row_out;  // valid in the rdy cycle
                got_col = col_out;
            end
        end
        if (!got) begin
            $display("timeout: no rdy within %0d cycles for %s", TIMEOUT, c.name());
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            #5;
            cmd = CMD_NOP;
        end
    endtask

    task automatic exercise(input dc_cmd_e c, input int k, input logic [DC_IDX_W-1:0] r,
                            input logic [DC_IDX_W-1:0] cc, input logic [DC_WORD_W-1:0] rin,
                            input logic [DC_WORD_W-1:0] cin);
        logic                 miss;
        logic                 exp_wb;
        logic                 exp_fill;
        int                   old_k;
        logic [DC_WORD_W-1:0] exp_col;
        miss     = !held_valid || held_k != k;
        exp_fill = c != CMD_FLUSH && miss;
        exp_wb   = held_valid && held_dirty && (c == CMD_FLUSH || miss);
        old_k    = held_k;
        run_cmd(c, k, r, cc, rin, cin);

        if (exp_wb) begin
            if (wr_addr_q.size() != DC_ROWS) begin
                report_mismatch("writeback count", DC_ROWS, wr_addr_q.size());
            end else begin
                for (int i = 0; i < DC_ROWS; i++) begin
                    if (wr_addr_q[i] != line_base(old_k) + DDR_ADDR_W'(i)) begin
                        report_mismatch("writeback addr", line_base(old_k) + i, wr_addr_q[i]);
                    end
                    if (wr_data_q[i] != golden[old_k][i]) begin
                        report_mismatch("writeback data", golden[old_k][i], wr_data_q[i]);
                    end
                end
            end
        end else if (wr_addr_q.size() != 0) begin
            $display("%s wrote %0d words to ddr on a clean line", c.name(), wr_addr_q.size());
            event_errs++;
        end

        if (exp_fill) begin
            if (fill_addr_q.size() != 1) begin
                $display("%s on a miss made %0d line reads, not one", c.name(), fill_addr_q.size());
                event_errs++;
            end else if (fill_addr_q[0] != line_base(k)) begin
                report_mismatch("fill addr", line_base(k), fill_addr_q[0]);
            end
        end else if (fill_addr_q.size() != 0) begin
            $display("%s requested a line read without a miss", c.name());
            event_errs++;
        end

        if (exp_wb) begin
            held_dirty = 1'b0;
        end
        if (exp_fill) begin
            held_valid = 1'b1;
            held_k     = k;
            held_dirty = 1'b0;
        end
        case (c)
            CMD_ROW_READ: begin
                if (got_row != golden[k][r]) begin
                    report_mismatch("row read", golden[k][r], got_row);
                end
            end
            CMD_COL_READ: begin
                for (int j = 0; j < DC_ROWS; j++) begin
                    exp_col[j] = golden[k][j][cc];  // bit j from word j
                end
                if (got_col != exp_col) begin
                    report_mismatch("col read", exp_col, got_col);
                end
            end
            CMD_ROW_WRITE: begin
                golden[k][r] = rin;
                held_dirty   = 1'b1;
            end
            CMD_COL_WRITE: begin
                for (int j = 0; j < DC_ROWS; j++) begin
                    golden[k][j][cc] = cin[j];
                end
                held_dirty = 1'b1;
            end
            CMD_FLUSH: begin
                if (exp_wb) begin
                    for (int i = 0; i < DC_ROWS; i++) begin
                        if (u_ddr.mem[line_base(old_k) + DDR_ADDR_W'(i)] != golden[old_k][i]) begin
                            report_mismatch("flush ddr contents", golden[old_k][i],
                                            u_ddr.mem[line_base(old_k) + DDR_ADDR_W'(i)]);
                        end
                    end
                end
            end
            default: ;
        endcase
        n_done++;
    endtask

    initial begin
        int      sel;
        dc_cmd_e c;
        void'($urandom(29));
        clk        = 1'b0;
        rst        = 1'b0;
        cmd        = CMD_NOP;
        addr       = '0;
        col        = '0;
        row_in     = '0;
        col_in     = '0;
        rd_req_q   = 1'b0;
        held_valid = 1'b0;
        held_k     = 0;
        held_dirty = 1'b0;
        value_errs = 0;
        event_errs = 0;
        n_done     = 0;
        tag_set[0] = 12'h01a;
        tag_set[1] = 12'h3c5;
        tag_set[2] = 12'h7f0;
        tag_set[3] = 12'hffe;
        for (int k = 0; k < 4; k++) begin
            for (int r = 0; r < DC_ROWS; r++) begin
                golden[k][r] = DC_WORD_W'($urandom);
                u_ddr.mem[line_base(k) + DDR_ADDR_W'(r)] = golden[k][r];
            end
        end

        repeat (4) @(posedge clk);
        #5;
        rst = 1'b1;
        @(posedge clk);
        if (rdy || ddr_rd_req || ddr_wr_req || fifo_rd_en) begin
            $display("a handshake output is high right after reset");
            event_errs++;
        end

        exercise(CMD_ROW_READ, 2, 4'd7, 4'd0, '0, '0);  // nothing valid yet so this must fill
        for (int n = 0; n < N_CMDS; n++) begin
            sel = $urandom % 10;
            if (sel < 3) c = CMD_ROW_READ;
            else if (sel < 5) c = CMD_ROW_WRITE;
            else if (sel < 7) c = CMD_COL_READ;
            else if (sel < 9) c = CMD_COL_WRITE;
            else c = CMD_FLUSH;
            exercise(c, $urandom % 4, DC_IDX_W'($urandom), DC_IDX_W'($urandom),
                     DC_WORD_W'($urandom), DC_WORD_W'($urandom));
        end

        // dirty a line and flush it twice in a row
        exercise(CMD_COL_WRITE, 1, 4'd0, 4'd9, 16'ha5c3, 16'h3c5a);
        exercise(CMD_FLUSH, 1, 4'd0, 4'd0, '0, '0);
        exercise(CMD_FLUSH, 1, 4'd0, 4'd0, '0, '0);
        // evict a written line and read it back
        exercise(CMD_ROW_WRITE, 3, 4'd5, 4'd0, 16'h1234, '0);
        exercise(CMD_ROW_READ, 0, 4'd2, 4'd0, '0, '0);
        exercise(CMD_ROW_READ, 3, 4'd5, 4'd0, '0, '0);

        $display("%0d commands, %0d value errors, %0d other errors",
                 n_done, value_errs, event_errs);
        if (value_errs == 0 && event_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/dc_pkg.sv
hw/bit_matrix.sv
hw/line_fill.sv
hw/line_writeback.sv
hw/cache_fsm.sv
hw/data_cache_top.sv
sim/tb_ddr_fifo.sv
sim/tb_data_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it and judge the log
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_data_cache \
    -o sim_data_cache \
    && ./obj_dir/sim_data_cache > sim.log 2>&1 \
    || { echo "build or run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
